// ==== rtl/fxp_pkg.sv ====
`default_nettype none

package fxp_pkg;

	// sign-magnitude format with a sign, 15 integer bits and 16 fraction bits
	localparam int FXP_W = 32;
	localparam int FXP_FRAC = 16;
	localparam int FXP_MAG_W = FXP_W - 1;

	// full width of the magnitude product before the fraction window is taken
	localparam int FXP_PROD_W = 2 * FXP_MAG_W;

	typedef logic [FXP_W-1:0] fxp_t;
	typedef logic [FXP_MAG_W-1:0] fxp_mag_t;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_MUL = 3'd2,
		OP_NEG = 3'd3,
		OP_ABS = 3'd4,
		OP_MAX = 3'd5
	} fxp_op_e;

	// field access
	function automatic logic fxp_sign(input fxp_t x);
		return x[FXP_W-1];
	endfunction

	function automatic fxp_mag_t fxp_mag(input fxp_t x);
		return x[FXP_MAG_W-1:0];
	endfunction

	function automatic fxp_t fxp_pack(input logic s, input fxp_mag_t m);
		return {s, m};
	endfunction

	// true for both +0 and -0
	function automatic logic fxp_is_zero(input fxp_t x);
		return fxp_mag(x) == '0;
	endfunction

	// sign flip, magnitude untouched
	function automatic fxp_t fxp_neg(input fxp_t x);
		return fxp_pack(~fxp_sign(x), fxp_mag(x));
	endfunction

	function automatic fxp_t fxp_abs(input fxp_t x);
		return fxp_pack(1'b0, fxp_mag(x));
	endfunction

endpackage

`default_nettype wire

// ==== rtl/fxp_add.sv ====
`default_nettype none

module fxp_add
	import fxp_pkg::*;
(
	input  fxp_t a,
	input  fxp_t b,
	output fxp_t sum
);

	logic     sign_a;
	logic     sign_b;
	fxp_mag_t mag_a;
	fxp_mag_t mag_b;

	logic     sign_sum;
	fxp_mag_t mag_sum;

	// a larger than b in magnitude, used only when signs differ
	logic     a_dominates;

	assign sign_a = fxp_sign(a);
	assign sign_b = fxp_sign(b);
	assign mag_a  = fxp_mag(a);
	assign mag_b  = fxp_mag(b);

	assign a_dominates = mag_a > mag_b;

	always_comb begin
		if (sign_a == sign_b) begin
			// equal signs add the magnitudes and lose the carry out of bit 30
			mag_sum  = mag_a + mag_b;
			sign_sum = sign_a;
		end else if (a_dominates) begin
			// a wins with opposite signs
			mag_sum  = mag_a - mag_b;
			sign_sum = sign_a;
		end else begin
			// b wins or ties with opposite signs
			// a tie leaves a zero magnitude with b's sign, cleaned up at the top
			mag_sum  = mag_b - mag_a;
			sign_sum = sign_b;
		end
	end

	assign sum = fxp_pack(sign_sum, mag_sum);

endmodule

`default_nettype wire

// ==== rtl/fxp_mul.sv ====
`default_nettype none

module fxp_mul
	import fxp_pkg::*;
(
	input  fxp_t a,
	input  fxp_t b,
	output fxp_t product
);

	fxp_mag_t              mag_a;
	fxp_mag_t              mag_b;
	logic [FXP_PROD_W-1:0] prod_full;
	fxp_mag_t              mag_prod;
	logic                  sign_prod;

	assign mag_a = fxp_mag(a);
	assign mag_b = fxp_mag(b);

	// 31 x 31 unsigned magnitude product with 32 fraction bits
	assign prod_full = mag_a * mag_b;

	// realign to 16 fraction bits
	// bits above the window are overflow and are dropped
	// bits below are truncated toward zero
	assign mag_prod = prod_full[FXP_FRAC+FXP_MAG_W-1:FXP_FRAC];

	assign sign_prod = fxp_sign(a) ^ fxp_sign(b);

	assign product = fxp_pack(sign_prod, mag_prod);

endmodule

`default_nettype wire

// ==== rtl/fxp_cmp.sv ====
`default_nettype none

module fxp_cmp
	import fxp_pkg::*;
(
	input  fxp_t a,
	input  fxp_t b,
	output logic lt,
	output logic eq,
	output logic gt
);

	logic     sign_a;
	logic     sign_b;
	fxp_mag_t mag_a;
	fxp_mag_t mag_b;
	logic     both_zero;
	logic     mag_lt;
	logic     mag_gt;

	assign sign_a = fxp_sign(a);
	assign sign_b = fxp_sign(b);
	assign mag_a  = fxp_mag(a);
	assign mag_b  = fxp_mag(b);

	// +0 and -0 compare equal
	assign both_zero = fxp_is_zero(a) && fxp_is_zero(b);

	assign mag_lt = mag_a < mag_b;
	assign mag_gt = mag_a > mag_b;

	always_comb begin
		lt = 1'b0;
		eq = 1'b0;
		gt = 1'b0;
		if (both_zero) begin
			eq = 1'b1;
		end else if (sign_a != sign_b) begin
			// the positive operand is larger even when one of them is zero
			gt = ~sign_a;
			lt = sign_a;
		end else if (!sign_a) begin
			// both positive
			gt = mag_gt;
			lt = mag_lt;
			eq = !mag_gt && !mag_lt;
		end else begin
			// among negatives the smaller magnitude is the larger number
			gt = mag_lt;
			lt = mag_gt;
			eq = !mag_gt && !mag_lt;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fxp_alu.sv ====
`default_nettype none

module fxp_alu
	import fxp_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  fxp_op_e op,
	input  fxp_t    a,
	input  fxp_t    b,
	output logic    out_valid,
	output fxp_t    result,
	output logic    lt,
	output logic    eq,
	output logic    gt
);

	// stage 1 operation register
	logic    s1_valid;
	fxp_op_e s1_op;
	fxp_t    s1_a;
	fxp_t    s1_b;

	// b into the adder with its sign flipped for subtract
	fxp_t    add_b;

	// unit outputs
	fxp_t    add_sum;
	fxp_t    mul_product;
	logic    cmp_lt;
	logic    cmp_eq;
	logic    cmp_gt;

	// selected and normalized result
	fxp_t    sel_result;
	fxp_t    norm_result;

	// stage 2 result register
	fxp_t    s2_result;
	logic    s2_lt;
	logic    s2_eq;
	logic    s2_gt;

	// stage 1 valid
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	// operand capture on every strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_op <= op;
			s1_a  <= a;
			s1_b  <= b;
		end
	end

	// subtract shares the adder
	assign add_b = (s1_op == OP_SUB) ? fxp_neg(s1_b) : s1_b;

	fxp_add u_add (
		.a   (s1_a),
		.b   (add_b),
		.sum (add_sum)
	);

	fxp_mul u_mul (
		.a       (s1_a),
		.b       (s1_b),
		.product (mul_product)
	);

	// flags are produced for every opcode and also steer max
	fxp_cmp u_cmp (
		.a  (s1_a),
		.b  (s1_b),
		.lt (cmp_lt),
		.eq (cmp_eq),
		.gt (cmp_gt)
	);

	// opcode select
	always_comb begin
		case (s1_op)
			OP_ADD,
			OP_SUB: begin
				sel_result = add_sum;
			end
			OP_MUL: begin
				sel_result = mul_product;
			end
			OP_NEG: begin
				sel_result = fxp_neg(s1_a);
			end
			OP_ABS: begin
				sel_result = fxp_abs(s1_a);
			end
			OP_MAX: begin
				// b only when a is strictly below it
				if (!cmp_gt && cmp_lt) begin
					sel_result = s1_b;
				end else begin
					sel_result = s1_a;
				end
			end
			default: begin
				// unused opcode values give positive zero
				sel_result = '0;
			end
		endcase
	end

	// a zero magnitude always leaves as +0 whatever produced it
	always_comb begin
		if (fxp_is_zero(sel_result)) begin
			norm_result = '0;
		end else begin
			norm_result = sel_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s1_valid;
		end
	end

	// result and flags load only with a live operation
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_result <= norm_result;
			s2_lt     <= cmp_lt;
			s2_eq     <= cmp_eq;
			s2_gt     <= cmp_gt;
		end
	end

	assign result = s2_result;
	assign lt     = s2_lt;
	assign eq     = s2_eq;
	assign gt     = s2_gt;

endmodule

`default_nettype wire

// ==== verif/fxp_clk_gen.sv ====
`default_nettype none

module fxp_clk_gen (
	output logic clk,
	output logic rst
);

	// 100 unit period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// power-on reset held for 16 rising edges
	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/fxp_alu_props.sv ====
`default_nettype none

module fxp_alu_props
	import fxp_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic out_valid,
	input  fxp_t result,
	input  logic lt,
	input  logic eq,
	input  logic gt
);

	// every accepted strobe gives a pulse two edges later
	a_latency: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after in_valid");

	a_no_spurious: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(in_valid, 2))
		else $error("out_valid without in_valid two cycles before");

	a_reset_clear: assert property (@(posedge clk)
		rst |=> !out_valid)
		else $error("out_valid high after a reset cycle");

	a_one_flag: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $onehot({lt, eq, gt}))
		else $error("compare flags not one-hot");

	// zero always leaves with a positive sign
	a_pos_zero: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !(result[FXP_W-1] && result[FXP_MAG_W-1:0] == '0))
		else $error("negative zero on result");

endmodule

bind fxp_alu fxp_alu_props u_props (.*);

`default_nettype wire

// ==== verif/fxp_alu_tb.sv ====
`default_nettype none

module fxp_alu_tb
	import fxp_pkg::*;
();

	logic    clk;
	logic    gen_rst;
	logic    tb_rst;
	logic    rst;
	logic    in_valid;
	fxp_op_e op;
	fxp_t    a;
	fxp_t    b;
	logic    out_valid;
	fxp_t    result;
	logic    lt;
	logic    eq;
	logic    gt;

	// expected results in issue order with flags packed as {lt, eq, gt}
	fxp_t        exp_res_q[$];
	logic [2:0]  exp_flg_q[$];
	int          exp_cyc_q[$];

	logic [31:0] lfsr_state;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          mark = 0;
	fxp_t        cmp_vals [6] = '{32'h0000_0000, 32'h8000_0000, 32'h0001_0000,
		32'h8001_0000, 32'h0000_8000, 32'h8000_8000};

	fxp_clk_gen u_clk_gen (
		.clk (clk),
		.rst (gen_rst)
	);

	// power-on reset or a reset forced mid-stream
	assign rst = gen_rst | tb_rst;

	fxp_alu UUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.lt        (lt),
		.eq        (eq),
		.gt        (gt)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// {lt, eq, gt} of x against y
	function automatic logic [2:0] flag_model(input fxp_t x, input fxp_t y);
		if (x[FXP_MAG_W-1:0] == '0 && y[FXP_MAG_W-1:0] == '0) begin
			return 3'b010;
		end
		if (x[FXP_W-1] != y[FXP_W-1]) begin
			return x[FXP_W-1] ? 3'b100 : 3'b001;
		end
		if (x[FXP_MAG_W-1:0] == y[FXP_MAG_W-1:0]) begin
			return 3'b010;
		end
		// larger magnitude wins among positives and loses among negatives
		if ((x[FXP_MAG_W-1:0] > y[FXP_MAG_W-1:0]) ^ x[FXP_W-1]) begin
			return 3'b001;
		end
		return 3'b100;
	endfunction

	function automatic fxp_t fxp_model(input fxp_op_e o, input fxp_t x, input fxp_t y);
		logic                  sx;
		logic                  sy;
		logic [FXP_MAG_W-1:0]  mx;
		logic [FXP_MAG_W-1:0]  my;
		logic [2*FXP_MAG_W-1:0] p;
		logic [2:0]            f;
		fxp_t                  r;
		sx = x[FXP_W-1];
		sy = y[FXP_W-1] ^ (o == OP_SUB);
		mx = x[FXP_MAG_W-1:0];
		my = y[FXP_MAG_W-1:0];
		p = {{FXP_MAG_W{1'b0}}, mx} * {{FXP_MAG_W{1'b0}}, my};
		f = flag_model(x, y);
		case (o)
			OP_ADD, OP_SUB: begin
				if (sx == sy) begin
					r = {sx, mx + my};
				end else if (mx > my) begin
					r = {sx, mx - my};
				end else begin
					r = {sy, my - mx};
				end
			end
			OP_MUL: r = {x[FXP_W-1] ^ y[FXP_W-1], p[FXP_FRAC+FXP_MAG_W-1:FXP_FRAC]};
			OP_NEG: r = {~x[FXP_W-1], mx};
			OP_ABS: r = {1'b0, mx};
			OP_MAX: r = (f[2] && !f[0]) ? y : x;
			default: r = '0;
		endcase
		if (r[FXP_MAG_W-1:0] == '0) begin
			r = '0;
		end
		return r;
	endfunction

	task automatic check_fxp(input string name, input fxp_t got, input fxp_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got %08h expected %08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input logic [2:0] got, input logic [2:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL lt/eq/gt got %h expected %h", got, exp);
			errors++;
		end
	endtask

	// compare each pulse against the oldest pending operation
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (out_valid === 1'b1) begin
			if (exp_res_q.size() == 0) begin
				$display("ERROR: out_valid pulse with no operation pending at cycle %0d", cyc);
				errors++;
			end else begin
				if (exp_cyc_q[0] != cyc) begin
					$display("ERROR: result arrived at cycle %0d instead of %0d",
						cyc, exp_cyc_q[0]);
					errors++;
				end
				check_fxp("result", result, exp_res_q.pop_front());
				check_flags({lt, eq, gt}, exp_flg_q.pop_front());
				exp_cyc_q.delete(0);
			end
		end
	end

	task automatic drive(input fxp_op_e o, input fxp_t x, input fxp_t y);
		in_valid <= 1'b1;
		op       <= o;
		a        <= x;
		b        <= y;
	endtask

	task automatic issue(input fxp_op_e o, input fxp_t x, input fxp_t y);
		@(posedge clk);
		drive(o, x, y);
		exp_res_q.push_back(fxp_model(o, x, y));
		exp_flg_q.push_back(flag_model(x, y));
		exp_cyc_q.push_back(cyc + 3);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic drain(input string what);
		int n;
		n = 0;
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_res_q.size() != 0 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (exp_res_q.size() != 0) begin
			$display("ERROR: timeout in %s, %0d results never arrived", what, exp_res_q.size());
			errors++;
			exp_res_q.delete();
			exp_flg_q.delete();
			exp_cyc_q.delete();
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		@(posedge clk);
		while (rst && n < 40) begin
			@(posedge clk);
			n++;
		end
		if (rst) begin
			$display("ERROR: reset was never released");
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s %s (%0d errors)", name, (errors == mark) ? "ok" : "failed",
			errors - mark);
		mark = errors;
	endtask

	initial begin
		fxp_t       x;
		fxp_t       y;
		logic [2:0] code;
		in_valid   = 1'b0;
		op         = OP_ADD;
		a          = '0;
		b          = '0;
		tb_rst     = 1'b0;
		lfsr_state = 32'hdcd1;

		// no pulse may appear before the first strobe
		wait_reset_release();
		idle(6);
		end_test("reset_idle");

		issue(OP_ADD, 32'h0001_0000, 32'h0000_8000);
		issue(OP_ADD, 32'h8001_0000, 32'h8000_8000);
		issue(OP_ADD, 32'h0001_0000, 32'h8000_8000);
		issue(OP_ADD, 32'h0000_8000, 32'h8001_0000);
		issue(OP_SUB, 32'h0001_0000, 32'h0001_0000);
		issue(OP_ADD, 32'h0001_0000, 32'h8001_0000);
		issue(OP_SUB, 32'h0001_0000, 32'h8000_8000);
		// magnitude wrap
		issue(OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		issue(OP_ADD, 32'hffff_ffff, 32'h8000_0002);
		drain("add_sub");
		end_test("add_sub");

		issue(OP_MUL, 32'h0001_0000, 32'h1234_5678);
		issue(OP_MUL, 32'h0000_8000, 32'h0000_8000);
		issue(OP_MUL, 32'h8000_8000, 32'h0000_8000);
		issue(OP_MUL, 32'h8001_0000, 32'h8003_4000);
		issue(OP_MUL, 32'h8000_0001, 32'h0000_00ff);
		issue(OP_MUL, 32'h0100_0000, 32'h0100_0000);
		drain("multiply");
		end_test("multiply");

		issue(OP_NEG, 32'h0000_0000, 32'h0);
		issue(OP_NEG, 32'h8000_0000, 32'h0);
		issue(OP_NEG, 32'h0001_0000, 32'h0);
		issue(OP_ABS, 32'h8001_0000, 32'h0);
		issue(OP_ABS, 32'h8000_0000, 32'h0);
		issue(OP_MAX, 32'h8001_0000, 32'h8000_8000);
		issue(OP_MAX, 32'h0001_0000, 32'h8002_0000);
		issue(OP_MAX, 32'h8000_0000, 32'h0000_0000);
		drain("neg_abs_max");
		end_test("neg_abs_max");

		// every ordered pair of signed zeros and small values
		foreach (cmp_vals[i]) begin
			foreach (cmp_vals[j]) begin
				issue(OP_MAX, cmp_vals[i], cmp_vals[j]);
			end
		end
		drain("compare");
		end_test("compare");

		for (int k = 0; k < 400; k++) begin
			x = rand_bits(32);
			y = (rand_bits(3) == 0) ? x : rand_bits(32);
			if (rand_bits(4) == 0) begin
				y[FXP_MAG_W-1:0] = '0;
			end
			code = 3'(rand_bits(3) % 6);
			issue(fxp_op_e'(code), x, y);
		end
		drain("random");
		end_test("random");

		// reset lands while two operations are in flight
		@(posedge clk);
		drive(OP_ADD, 32'h0001_0000, 32'h0001_0000);
		@(posedge clk);
		drive(OP_MUL, 32'h0002_0000, 32'h0003_0000);
		tb_rst <= 1'b1;
		@(posedge clk);
		in_valid <= 1'b0;
		@(posedge clk);
		tb_rst <= 1'b0;
		idle(6);
		issue(OP_SUB, 32'h0003_0000, 32'h0001_0000);
		issue(OP_ABS, 32'h8004_0000, 32'h0);
		drain("reset_mid_stream");
		end_test("reset_mid_stream");

		$display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/fxp_pkg.sv
rtl/fxp_add.sv
rtl/fxp_mul.sv
rtl/fxp_cmp.sv
rtl/fxp_alu.sv
verif/fxp_clk_gen.sv
verif/fxp_alu_props.sv
verif/fxp_alu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fxp_alu_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
